// File: Makefile
VERILATOR  ?= verilator
TOP        := ing_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/ing_buffer.sv
/* Sends complete packets only, one whole packet at a time, in round-robin port order.
   The bus idles for two cycles between packets */
`timescale 1ns/1ps

module ing_buffer (
    input  logic                           ing_clk,
    input  logic                           rst_n,
    input  logic [ing_pkg::NUM_PORTS-1:0]  word_valid,
    input  ing_pkg::wide_beat_t            words [ing_pkg::NUM_PORTS-1:0],
    input  logic                           out_ready,
    output logic                           out_valid,
    output ing_pkg::out_beat_t             out_beat,
    output logic [ing_pkg::NUM_PORTS-1:0]  ok,
    output logic [ing_pkg::NUM_PORTS-1:0]  ovf
);

    import ing_pkg::*;

    sched_state_t         state;
    port_idx_t            grant;
    port_idx_t            rr_ptr;
    port_idx_t            pick;
    logic                 found;
    logic                 load;
    logic [NUM_PORTS-1:0] pkt_avail;
    logic [NUM_PORTS-1:0] rd;
    wide_beat_t           heads [NUM_PORTS-1:0];

    ////////////////////
    // Partitions

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_part
        ing_pkt_fifo u_fifo (
            .ing_clk    (ing_clk),
            .rst_n      (rst_n),
            .word_valid (word_valid[p]),
            .word       (words[p]),
            .rd         (rd[p]),
            .head       (heads[p]),
            .pkt_avail  (pkt_avail[p]),
            .ok         (ok[p]),
            .ovf        (ovf[p])
        );
        assign rd[p] = load && (grant == port_idx_t'(p));
    end

    ////////////////////
    // Scheduler

    // First port at or after rr_ptr holding a complete packet
    always_comb begin
        port_idx_t cand;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = rr_ptr + port_idx_t'(i);
            if (!found && pkt_avail[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // Stop pulling once the last word sits in the output register
    assign load = (state == SEND) && (!out_valid || (out_ready && !out_beat.beat.last));

    always_ff @(posedge ing_clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            grant  <= '0;
            rr_ptr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (found) begin
                        grant  <= pick;
                        rr_ptr <= pick + 1'b1;
                        state  <= SEND;
                    end
                end
                SEND: begin
                    if (out_valid && out_ready && out_beat.beat.last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge ing_clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge ing_clk) begin
        if (load) begin
            out_beat.beat <= heads[grant];
            out_beat.port <= grant;
        end
    end

endmodule

// File: logic/ing_pkg.sv
/* Fixed four-port mix (8/16/32/64-bit) onto one 64-bit bus; partition depth must stay a
   power of two because the pointers wrap on their own width */
package ing_pkg;

    ////////////////////
    // Port mix and bus

    localparam int NUM_PORTS = 4;
    localparam int BUS_BYTES = 8;

    // Port n is PORT_BYTES[n] bytes wide
    localparam int PORT_BYTES [NUM_PORTS] = '{1, 2, 4, 8};

    ////////////////////
    // Buffer sizing

    localparam int MTU_BYTES  = 128;
    localparam int MTU_WORDS  = (MTU_BYTES + BUS_BYTES - 1) / BUS_BYTES;

    // Two MTUs per port, rounded up to a power of two
    localparam int BUF_DEPTH  = 2 ** $clog2(2 * MTU_WORDS);
    localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);

    ////////////////////
    // Types

    typedef logic [BUS_BYTES*8-1:0]       bus_data_t;
    typedef logic [BUS_BYTES-1:0]         bus_keep_t;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;
    typedef logic [31:0]                  stat_cnt_t;
    typedef logic [63:0]                  pkt_cnt_t;

    // One bus word of a packet
    typedef struct packed {
        bus_data_t data;
        bus_keep_t keep;
        logic      last;
    } wide_beat_t;

    // Output beat, tagged with the port it came from
    typedef struct packed {
        wide_beat_t beat;
        port_idx_t  port;
    } out_beat_t;

    typedef enum logic {
        IDLE,
        SEND
    } sched_state_t;

endpackage

// File: logic/ing_pkt_fifo.sv
/* One port's partition. Words become readable only once their packet's last word is in;
   a packet that runs out of room is dropped whole and never back-pressures the port */
`timescale 1ns/1ps

module ing_pkt_fifo (
    input  logic                ing_clk,
    input  logic                rst_n,
    input  logic                word_valid,
    input  ing_pkg::wide_beat_t word,
    input  logic                rd,
    output ing_pkg::wide_beat_t head,
    output logic                pkt_avail,
    output logic                ok,
    output logic                ovf
);

    import ing_pkg::*;

    wide_beat_t mem [BUF_DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [BUF_ADDR_W:0] wr_ptr;
    logic [BUF_ADDR_W:0] cmt_ptr;
    logic [BUF_ADDR_W:0] rd_ptr;
    logic [BUF_ADDR_W:0] used;
    logic [BUF_ADDR_W:0] pkt_cnt;

    logic dropping;
    logic full;
    logic wr_en;
    logic commit;
    logic pkt_done;

    assign used      = wr_ptr - rd_ptr;
    assign full      = used[BUF_ADDR_W];
    assign wr_en     = word_valid && !dropping && !full;
    assign commit    = wr_en && word.last;
    assign pkt_done  = rd && head.last;
    assign pkt_avail = (pkt_cnt != '0);
    assign head      = mem[rd_ptr[BUF_ADDR_W-1:0]];

    always_ff @(posedge ing_clk) begin
        if (wr_en) begin
            mem[wr_ptr[BUF_ADDR_W-1:0]] <= word;
        end
    end

    always_ff @(posedge ing_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            cmt_ptr  <= '0;
            rd_ptr   <= '0;
            pkt_cnt  <= '0;
            dropping <= 1'b0;
            ok       <= 1'b0;
            ovf      <= 1'b0;
        end else begin
            ok  <= commit;
            ovf <= word_valid && word.last && (dropping || full);

            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (word_valid) begin
                if (dropping) begin
                    // Swallow the rest of a packet that did not fit
                    if (word.last) begin
                        dropping <= 1'b0;
                    end
                end else if (full) begin
                    wr_ptr   <= cmt_ptr;
                    dropping <= !word.last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (word.last) begin
                        cmt_ptr <= wr_ptr + 1'b1;
                    end
                end
            end

            case ({commit, pkt_done})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

endmodule

// File: logic/ing_port_stats.sv
/* Counters saturate rather than wrap; clear wins over a pulse in the same cycle */
`timescale 1ns/1ps

module ing_port_stats (
    input  logic               ing_clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               ok,
    input  logic               drop_dis,
    input  logic               drop_ovf,
    output ing_pkg::stat_cnt_t cnt_ok,
    output ing_pkg::stat_cnt_t cnt_drop_dis,
    output ing_pkg::stat_cnt_t cnt_drop_ovf
);

    import ing_pkg::*;

    // Index 0 accepted, 1 disabled drops, 2 overflow drops
    stat_cnt_t  cnt [3];
    logic [2:0] pulse;

    assign pulse = {drop_ovf, drop_dis, ok};

    always_ff @(posedge ing_clk) begin
        if (!rst_n || clear) begin
            cnt <= '{default: '0};
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (pulse[i] && !(&cnt[i])) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign cnt_ok       = cnt[0];
    assign cnt_drop_dis = cnt[1];
    assign cnt_drop_ovf = cnt[2];

endmodule

// File: logic/ing_top.sv
/* Input ports have no ready and are never stalled; a packet that overflows its partition
   is lost and reported on buf_overflow. Single clock domain */
`timescale 1ns/1ps

module ing_top (
    input  logic                                   ing_clk,
    input  logic                                   rst_n,
    input  logic                                   in_valid_0,
    input  logic [ing_pkg::PORT_BYTES[0]*8-1:0]    in_data_0,
    input  logic [ing_pkg::PORT_BYTES[0]-1:0]      in_keep_0,
    input  logic                                   in_last_0,
    input  logic                                   in_valid_1,
    input  logic [ing_pkg::PORT_BYTES[1]*8-1:0]    in_data_1,
    input  logic [ing_pkg::PORT_BYTES[1]-1:0]      in_keep_1,
    input  logic                                   in_last_1,
    input  logic                                   in_valid_2,
    input  logic [ing_pkg::PORT_BYTES[2]*8-1:0]    in_data_2,
    input  logic [ing_pkg::PORT_BYTES[2]-1:0]      in_keep_2,
    input  logic                                   in_last_2,
    input  logic                                   in_valid_3,
    input  logic [ing_pkg::PORT_BYTES[3]*8-1:0]    in_data_3,
    input  logic [ing_pkg::PORT_BYTES[3]-1:0]      in_keep_3,
    input  logic                                   in_last_3,
    input  logic [ing_pkg::NUM_PORTS-1:0]          port_enable,
    input  logic [ing_pkg::NUM_PORTS-1:0]          stats_clear,
    input  logic                                   pkt_cnt_clear,
    input  logic                                   out_ready,
    output logic                                   out_valid,
    output ing_pkg::out_beat_t                     out_beat,
    output ing_pkg::pkt_cnt_t                      pkt_cnt,
    output logic [ing_pkg::NUM_PORTS-1:0]          buf_overflow,
    output ing_pkg::stat_cnt_t                     stat_ok       [ing_pkg::NUM_PORTS-1:0],
    output ing_pkg::stat_cnt_t                     stat_drop_dis [ing_pkg::NUM_PORTS-1:0],
    output ing_pkg::stat_cnt_t                     stat_drop_ovf [ing_pkg::NUM_PORTS-1:0]
);

    import ing_pkg::*;

    logic [NUM_PORTS-1:0] word_valid;
    logic [NUM_PORTS-1:0] drop_dis;
    logic [NUM_PORTS-1:0] ok;
    wide_beat_t           words [NUM_PORTS-1:0];

    ////////////////////
    // Width adapters

    ing_width_adapt #(.IN_BYTES(PORT_BYTES[0])) u_adapt_0 (
        .ing_clk, .rst_n, .in_valid(in_valid_0), .in_data(in_data_0), .in_keep(in_keep_0),
        .in_last(in_last_0), .enable(port_enable[0]), .word_valid(word_valid[0]),
        .word(words[0]), .drop_dis(drop_dis[0])
    );

    ing_width_adapt #(.IN_BYTES(PORT_BYTES[1])) u_adapt_1 (
        .ing_clk, .rst_n, .in_valid(in_valid_1), .in_data(in_data_1), .in_keep(in_keep_1),
        .in_last(in_last_1), .enable(port_enable[1]), .word_valid(word_valid[1]),
        .word(words[1]), .drop_dis(drop_dis[1])
    );

    ing_width_adapt #(.IN_BYTES(PORT_BYTES[2])) u_adapt_2 (
        .ing_clk, .rst_n, .in_valid(in_valid_2), .in_data(in_data_2), .in_keep(in_keep_2),
        .in_last(in_last_2), .enable(port_enable[2]), .word_valid(word_valid[2]),
        .word(words[2]), .drop_dis(drop_dis[2])
    );

    ing_width_adapt #(.IN_BYTES(PORT_BYTES[3])) u_adapt_3 (
        .ing_clk, .rst_n, .in_valid(in_valid_3), .in_data(in_data_3), .in_keep(in_keep_3),
        .in_last(in_last_3), .enable(port_enable[3]), .word_valid(word_valid[3]),
        .word(words[3]), .drop_dis(drop_dis[3])
    );

    ////////////////////
    // Buffer and scheduler

    ing_buffer u_buffer (
        .ing_clk, .rst_n, .word_valid, .words, .out_ready, .out_valid, .out_beat,
        .ok, .ovf(buf_overflow)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_stats
        ing_port_stats u_stats (
            .ing_clk, .rst_n, .clear(stats_clear[p]), .ok(ok[p]), .drop_dis(drop_dis[p]),
            .drop_ovf(buf_overflow[p]), .cnt_ok(stat_ok[p]),
            .cnt_drop_dis(stat_drop_dis[p]), .cnt_drop_ovf(stat_drop_ovf[p])
        );
    end

    // Counts packets handed off on the output bus
    always_ff @(posedge ing_clk) begin
        if (!rst_n || pkt_cnt_clear) begin
            pkt_cnt <= '0;
        end else if (out_valid && out_ready && out_beat.beat.last && !(&pkt_cnt)) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

endmodule

// File: logic/ing_width_adapt.sv
/* Non-last beats must carry a full keep; IN_BYTES must divide the bus width so a beat never
   straddles two words. Enable is sampled only on the first beat of a packet */
`timescale 1ns/1ps

module ing_width_adapt #(
    parameter int IN_BYTES = 1
) (
    input  logic                  ing_clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [IN_BYTES*8-1:0] in_data,
    input  logic [IN_BYTES-1:0]   in_keep,
    input  logic                  in_last,
    input  logic                  enable,
    output logic                  word_valid,
    output ing_pkg::wide_beat_t   word,
    output logic                  drop_dis
);

    import ing_pkg::*;

    // Bytes already gathered in the assembly register
    logic [$clog2(BUS_BYTES)-1:0] fill;
    logic [$clog2(BUS_BYTES):0]   fill_next;

    logic      in_pkt;
    logic      pkt_en;
    logic      cur_en;
    logic      take;
    logic      emit;
    bus_data_t asm_data;
    bus_data_t merged;
    bus_keep_t merged_keep;

    // Mid-packet the latched enable rules, otherwise the live one
    assign cur_en    = in_pkt ? pkt_en : enable;
    assign take      = in_valid && cur_en;
    assign fill_next = fill + ($clog2(BUS_BYTES) + 1)'(IN_BYTES);
    assign emit      = in_last || (fill_next == BUS_BYTES);

    ////////////////////
    // Word assembly

    always_comb begin
        merged_keep = ~({BUS_BYTES{1'b1}} << fill) | (bus_keep_t'(in_keep) << fill);
        merged = (fill == '0) ? '0 : asm_data;
        merged = merged | (bus_data_t'(in_data) << (8 * fill));
        // Bytes past keep on a short last beat are zeroed
        for (int b = 0; b < BUS_BYTES; b++) begin
            if (!merged_keep[b]) begin
                merged[8*b +: 8] = '0;
            end
        end
    end

    always_ff @(posedge ing_clk) begin
        if (take) begin
            asm_data <= merged;
        end
        if (take && emit) begin
            word.data <= merged;
            word.keep <= merged_keep;
            word.last <= in_last;
        end
    end

    ////////////////////
    // Packet tracking

    always_ff @(posedge ing_clk) begin
        if (!rst_n) begin
            in_pkt     <= 1'b0;
            pkt_en     <= 1'b0;
            fill       <= '0;
            word_valid <= 1'b0;
            drop_dis   <= 1'b0;
        end else begin
            word_valid <= take && emit;
            // One pulse per discarded packet, at its last beat
            drop_dis   <= in_valid && in_last && !cur_en;
            if (in_valid) begin
                in_pkt <= !in_last;
                if (!in_pkt) begin
                    pkt_en <= enable;
                end
            end
            if (take) begin
                fill <= emit ? '0 : fill_next[$clog2(BUS_BYTES)-1:0];
            end
        end
    end

endmodule

// File: tests/ing_tb.sv
/* Drives all four ports through the ingress subsystem and checks the output stream per port.
   Input pacing keeps each partition within its two-MTU budget except in the overflow test */
`timescale 1ns/1ps

module ing_tb;

    import ing_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RAND_PKTS  = 40;
    localparam int NUM_PKTS   = NUM_PORTS * MTU_BYTES + NUM_PORTS * RAND_PKTS + 16;
    localparam longint TIMEOUT_NS = longint'(NUM_PKTS) * MTU_WORDS * 16 * CLK_PERIOD;

    logic                 ing_clk;
    logic                 rst_n;
    logic [63:0]          drv_data [NUM_PORTS];
    logic [7:0]           drv_keep [NUM_PORTS];
    logic [NUM_PORTS-1:0] drv_valid;
    logic [NUM_PORTS-1:0] drv_last;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] stats_clear;
    logic                 pkt_cnt_clear;
    logic                 out_ready;
    logic                 out_valid;
    out_beat_t            out_beat;
    pkt_cnt_t             pkt_cnt;
    logic [NUM_PORTS-1:0] buf_overflow;
    stat_cnt_t            stat_ok       [NUM_PORTS-1:0];
    stat_cnt_t            stat_drop_dis [NUM_PORTS-1:0];
    stat_cnt_t            stat_drop_ovf [NUM_PORTS-1:0];

    // Expected output words per port, in arrival order
    out_beat_t  exp_q [NUM_PORTS][$];
    port_idx_t  order_q [$];
    out_beat_t  want;
    int         exp_ok   [NUM_PORTS] = '{default: 0};
    int         exp_dis  [NUM_PORTS] = '{default: 0};
    int         exp_ovf  [NUM_PORTS] = '{default: 0};
    int         ovf_seen [NUM_PORTS] = '{default: 0};
    int         occ      [NUM_PORTS] = '{default: 0};
    int         rlen     [NUM_PORTS][RAND_PKTS];
    logic [7:0] rbase    [NUM_PORTS][RAND_PKTS];
    longint     exp_pkts   = 0;
    int         errors     = 0;
    int         total_pkts = 0;
    bit         hold_occ   = 1'b0;
    bit         rand_ready = 1'b0;
    bit         mid_pkt    = 1'b0;
    port_idx_t  cur_port   = '0;
    integer     seed       = 32'h4980_d15a;
    logic [31:0] r;

    ing_top u_dut (
        .ing_clk, .rst_n,
        .in_valid_0(drv_valid[0]), .in_data_0(drv_data[0][7:0]),
        .in_keep_0(drv_keep[0][0:0]), .in_last_0(drv_last[0]),
        .in_valid_1(drv_valid[1]), .in_data_1(drv_data[1][15:0]),
        .in_keep_1(drv_keep[1][1:0]), .in_last_1(drv_last[1]),
        .in_valid_2(drv_valid[2]), .in_data_2(drv_data[2][31:0]),
        .in_keep_2(drv_keep[2][3:0]), .in_last_2(drv_last[2]),
        .in_valid_3(drv_valid[3]), .in_data_3(drv_data[3]),
        .in_keep_3(drv_keep[3]), .in_last_3(drv_last[3]),
        .port_enable, .stats_clear, .pkt_cnt_clear, .out_ready, .out_valid, .out_beat,
        .pkt_cnt, .buf_overflow, .stat_ok, .stat_drop_dis, .stat_drop_ovf
    );

    initial begin
        ing_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ing_clk = ~ing_clk;
    end

    ////////////////////
    // Reference model

    function automatic logic [7:0] byte_at(input logic [7:0] base, input int i);
        return 8'(base + i * 29);
    endfunction

    // Returns 0 when the packet would not fit its partition
    function automatic bit model_pkt(input int p, input int len, input logic [7:0] base);
        out_beat_t w;
        int nw;
        nw = (len + BUS_BYTES - 1) / BUS_BYTES;
        if (hold_occ) begin
            if (occ[p] + nw > BUF_DEPTH) begin
                return 1'b0;
            end
            occ[p] += nw;
        end
        for (int i = 0; i < nw; i++) begin
            w = '0;
            w.port = port_idx_t'(p);
            for (int b = 0; b < BUS_BYTES; b++) begin
                if (i * BUS_BYTES + b < len) begin
                    w.beat.data[8*b +: 8] = byte_at(base, i * BUS_BYTES + b);
                    w.beat.keep[b] = 1'b1;
                end
            end
            w.beat.last = (i == nw - 1);
            exp_q[p].push_back(w);
        end
        exp_pkts++;
        return 1'b1;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // Stimulus

    // dis_beat clears the port enable on that beat, -1 leaves it alone
    task automatic send_pkt(input int p, input int len, input logic [7:0] base,
                            input int dis_beat);
        int nb;
        int pos;
        nb = PORT_BYTES[p];
        while (!hold_occ && exp_q[p].size() > BUF_DEPTH - MTU_WORDS) begin
            @(negedge ing_clk);
        end
        total_pkts++;
        if (!port_enable[p]) begin
            exp_dis[p]++;
        end else if (model_pkt(p, len, base)) begin
            exp_ok[p]++;
        end else begin
            exp_ovf[p]++;
        end
        pos = 0;
        while (pos < len) begin
            @(negedge ing_clk);
            drv_valid[p] = 1'b1;
            drv_data[p]  = '0;
            drv_keep[p]  = '0;
            for (int b = 0; b < nb; b++) begin
                if (pos + b < len) begin
                    drv_data[p][8*b +: 8] = byte_at(base, pos + b);
                    drv_keep[p][b] = 1'b1;
                end
            end
            drv_last[p] = (pos + nb >= len);
            if (pos / nb == dis_beat) begin
                port_enable[p] = 1'b0;
            end
            pos += nb;
        end
        @(negedge ing_clk);
        drv_valid[p] = 1'b0;
        drv_last[p]  = 1'b0;
    endtask

    task automatic send_sweep(input int p);
        for (int len = 1; len <= MTU_BYTES; len++) begin
            send_pkt(p, len, 8'(len * 7 + p * 61), -1);
        end
    endtask

    task automatic send_rand(input int p);
        for (int k = 0; k < RAND_PKTS; k++) begin
            send_pkt(p, rlen[p][k], rbase[p][k], -1);
        end
    endtask

    task automatic drain();
        while (pending() != 0 || out_valid) begin
            @(negedge ing_clk);
        end
        repeat (4) @(negedge ing_clk);
    endtask

    task automatic check_stats();
        for (int p = 0; p < NUM_PORTS; p++) begin
            compare_value($sformatf("stat_ok[%0d]", p), stat_ok[p], exp_ok[p]);
            compare_value($sformatf("stat_drop_dis[%0d]", p), stat_drop_dis[p], exp_dis[p]);
            compare_value($sformatf("stat_drop_ovf[%0d]", p), stat_drop_ovf[p], exp_ovf[p]);
            compare_value($sformatf("buf_overflow[%0d] pulses", p), ovf_seen[p], exp_ovf[p]);
        end
        compare_value("pkt_cnt", pkt_cnt, exp_pkts);
    endtask

    ////////////////////
    // Scoreboard

    always @(posedge ing_clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (buf_overflow[p]) begin
                    ovf_seen[p]++;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q[out_beat.port].size() == 0) begin
                    $display("Error at %0t ns: a beat came out of port %0d with none expected",
                             $time, out_beat.port);
                    errors++;
                end else begin
                    // The port tag selects the queue, so a wrong tag shows up as wrong data
                    want = exp_q[out_beat.port].pop_front();
                    compare_value("out_beat.beat.data", out_beat.beat.data, want.beat.data);
                    compare_value("out_beat.beat.keep", out_beat.beat.keep, want.beat.keep);
                    compare_value("out_beat.beat.last", out_beat.beat.last, want.beat.last);
                end
                // Another port must not break into a packet
                if (mid_pkt) begin
                    compare_value("out_beat.port within packet", out_beat.port, cur_port);
                end else begin
                    order_q.push_back(out_beat.port);
                end
                mid_pkt  = !out_beat.beat.last;
                cur_port = out_beat.port;
            end
        end
    end

    // Random back-pressure, active only while rand_ready is set
    initial begin
        forever begin
            @(negedge ing_clk);
            if (rand_ready) begin
                r = $random(seed);
                out_ready = r[0];
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t ns with %0d words still expected, %0d errors",
                 $time, pending(), errors);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // Test sequence

    initial begin
        rst_n         = 1'b0;
        drv_valid     = '0;
        drv_last      = '0;
        drv_data      = '{default: '0};
        drv_keep      = '{default: '0};
        port_enable   = '1;
        stats_clear   = '0;
        pkt_cnt_clear = 1'b0;
        out_ready     = 1'b0;
        repeat (4) @(posedge ing_clk);
        @(negedge ing_clk);
        rst_n = 1'b1;

        // Round-robin order with everything held back
        send_pkt(0, 5, 8'h10, -1);
        while (!out_valid) begin
            @(negedge ing_clk);
        end
        fork
            send_pkt(1, 9, 8'h20, -1);
            send_pkt(2, 17, 8'h30, -1);
            send_pkt(3, 40, 8'h40, -1);
        join
        repeat (4) @(negedge ing_clk);
        out_ready = 1'b1;
        drain();
        if (order_q.size() != NUM_PORTS) begin
            $display("Error: %0d packets left the bus in the order test instead of four",
                     order_q.size());
            errors++;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                compare_value("packet order port", order_q[i], i);
            end
        end
        check_stats();

        // Every length on every port
        fork
            send_sweep(0);
            send_sweep(1);
            send_sweep(2);
            send_sweep(3);
        join
        drain();
        check_stats();

        // Random traffic under random back-pressure
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < RAND_PKTS; k++) begin
                r = $random(seed);
                rlen[p][k]  = int'(r % MTU_BYTES) + 1;
                rbase[p][k] = r[15:8];
            end
        end
        rand_ready = 1'b1;
        fork
            send_rand(0);
            send_rand(1);
            send_rand(2);
            send_rand(3);
        join
        drain();
        rand_ready = 1'b0;
        @(negedge ing_clk);
        out_ready = 1'b1;
        check_stats();

        // Disabled ports drop, a mid-packet disable does not
        port_enable = 4'b1001;
        send_pkt(1, 12, 8'h51, -1);
        send_pkt(2, 30, 8'h52, -1);
        port_enable = '1;
        send_pkt(0, 10, 8'h53, 3);
        send_pkt(3, 64, 8'h54, 2);
        port_enable = '1;
        drain();
        check_stats();

        // Third full-size packet on port 3 cannot fit
        out_ready = 1'b0;
        hold_occ  = 1'b1;
        occ[3]    = 0;
        for (int k = 0; k < 3; k++) begin
            send_pkt(3, MTU_BYTES, 8'(8'hA0 + k), -1);
        end
        repeat (8) @(negedge ing_clk);
        compare_value("buf_overflow[3] pulses while held", ovf_seen[3], exp_ovf[3]);
        hold_occ  = 1'b0;
        out_ready = 1'b1;
        drain();
        check_stats();

        // Counter clears
        pkt_cnt_clear = 1'b1;
        stats_clear   = '1;
        @(negedge ing_clk);
        pkt_cnt_clear = 1'b0;
        stats_clear   = '0;
        exp_pkts = 0;
        exp_ok   = '{default: 0};
        exp_dis  = '{default: 0};
        exp_ovf  = '{default: 0};
        ovf_seen = '{default: 0};
        @(negedge ing_clk);
        check_stats();

        $display("Finished %0d packets with %0d errors", total_pkts, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tests/ing_tb_assert.sv
/* Output handshake rules of the buffer; bound into every ing_buffer instance */
`timescale 1ns/1ps

module ing_buffer_assert (
    input logic               ing_clk,
    input logic               rst_n,
    input logic               out_valid,
    input logic               out_ready,
    input ing_pkg::out_beat_t out_beat
);

    import ing_pkg::*;

    // A stalled beat must not change under the consumer
    hold_steady: assert property (@(posedge ing_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("out_beat changed while stalled");

    reset_quiet: assert property (@(posedge ing_clk)
        !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

    // Inside a packet the port tag stays put
    port_fixed: assert property (@(posedge ing_clk) disable iff (!rst_n)
        out_valid && out_ready && !out_beat.beat.last |=> $stable(out_beat.port))
        else $error("port tag changed inside a packet");

endmodule

bind ing_buffer ing_buffer_assert u_assert (
    .ing_clk   (ing_clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
);

// File: verilog.f
logic/ing_pkg.sv
logic/ing_width_adapt.sv
logic/ing_pkt_fifo.sv
logic/ing_buffer.sv
logic/ing_port_stats.sv
logic/ing_top.sv
tests/ing_tb_assert.sv
tests/ing_tb.sv
